// File: flist.f
hw/csr_pkg.sv
hw/csr_ctrl.sv
hw/csr_alu.sv
hw/csr_file.sv
hw/csr_top.sv
test/tb_clkgen.sv
test/csr_assertions.sv
test/csr_tb.sv

// File: Makefile
# Verilator build and run of the CSR testbench.

VERILATOR ?= verilator
TOP       ?= csr_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/csr_tb.sv
// csr testbench drives random CSR and trap operations and checks them against a register model.
`timescale 1ns/1ns
`default_nettype none

module csr_tb;
  import csr_pkg::*;

  localparam int N_RW      = 200;
  localparam int N_MIXED   = 200;
  localparam int N_ILLEGAL = 40;
  // every random operation is followed by one read, plus room for the short tests.
  localparam int MAX_CYCLES = 2 * N_RW + 2 * N_MIXED + N_ILLEGAL + 100;

  logic      clk;
  logic      arst_n;
  logic      valid;
  csr_op_t   op;
  csr_addr_t addr;
  csr_data_t wdata;
  csr_data_t pc;
  csr_data_t rdata;
  logic      illegal;
  logic      redirect;
  csr_data_t redirect_pc;

  // slots follow the register index order mstatus, mtvec, mepc, mcause, mscratch.
  csr_data_t model [5];
  csr_addr_t addr_table [5];
  int        errors = 0;
  int        checks = 0;
  int        err_mark = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  int        cycles = 0;

  tb_clkgen u_clkgen (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  csr_top i_dut (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_valid       (valid),
    .i_op          (op),
    .i_addr        (addr),
    .i_wdata       (wdata),
    .i_pc          (pc),
    .o_rdata       (rdata),
    .o_illegal     (illegal),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string name, input csr_data_t got, input csr_data_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic int slot_of(input csr_addr_t a);
    int slot;
    slot = -1;
    for (int k = 0; k < 5; k++) begin
      if (addr_table[k] == a) begin
        slot = k;
      end
    end
    return slot;
  endfunction

  function automatic csr_data_t wmask_for(input int slot);
    case (slot)
      0:       return WMASK_MSTATUS;
      1:       return WMASK_MTVEC;
      2:       return WMASK_MEPC;
      3:       return WMASK_MCAUSE;
      4:       return WMASK_MSCRATCH;
      default: return '0;
    endcase
  endfunction

  function automatic csr_data_t rand_data();
    return {$urandom, $urandom};
  endfunction

  function automatic csr_addr_t rand_legal_addr();
    int k;
    k = int'($urandom % 5);
    return addr_table[k];
  endfunction

  function automatic csr_addr_t rand_illegal_addr();
    csr_addr_t a;
    a = 12'($urandom);
    while (slot_of(a) >= 0) begin
      a = 12'($urandom);
    end
    return a;
  endfunction

  function automatic csr_op_t rand_csr_op();
    int k;
    k = int'($urandom % 3);
    case (k)
      0:       return OP_CSRRW;
      1:       return OP_CSRRS;
      default: return OP_CSRRC;
    endcase
  endfunction

  // one instruction: predict, drive, sample mid-cycle, compare, then update the model.
  task automatic run_op(input csr_op_t o, input csr_addr_t a, input csr_data_t d,
                        input csr_data_t p, output csr_data_t got);
    int        slot;
    logic      is_csr;
    csr_data_t old;
    csr_data_t cand;
    csr_data_t m;
    csr_data_t exp_rdata;
    csr_data_t exp_target;
    slot = slot_of(a);
    is_csr = (o == OP_CSRRW) || (o == OP_CSRRS) || (o == OP_CSRRC);
    exp_rdata = '0;
    exp_target = '0;
    if (is_csr && slot >= 0) begin
      exp_rdata = model[slot];
    end
    if (o == OP_ECALL) begin
      exp_target = model[1];
    end else if (o == OP_MRET) begin
      exp_target = model[2];
    end
    @(posedge clk);
    valid <= 1'b1;
    op    <= o;
    addr  <= a;
    wdata <= d;
    pc    <= p;
    @(negedge clk);
    got = rdata;
    check_value("o_rdata", rdata, exp_rdata);
    check_value("o_illegal", 64'(illegal), 64'(is_csr && slot < 0));
    check_value("o_redirect", 64'(redirect), 64'(!is_csr));
    check_value("o_redirect_pc", redirect_pc, exp_target);
    if (is_csr && slot >= 0) begin
      old = model[slot];
      m = wmask_for(slot);
      case (o)
        OP_CSRRW: cand = d;
        OP_CSRRS: cand = old | d;
        default:  cand = old & ~d;
      endcase
      model[slot] = (cand & m) | (old & ~m);
    end else if (o == OP_ECALL) begin
      model[2] = {p[63:2], 2'b00};
      model[3] = MCAUSE_ECALL_M;
      model[0][MSTATUS_MPIE_BIT] = model[0][MSTATUS_MIE_BIT];
      model[0][MSTATUS_MIE_BIT] = 1'b0;
    end else if (o == OP_MRET) begin
      model[0][MSTATUS_MIE_BIT] = model[0][MSTATUS_MPIE_BIT];
      model[0][MSTATUS_MPIE_BIT] = 1'b1;
    end
  endtask

  task automatic read_csr(input csr_addr_t a, output csr_data_t got);
    run_op(OP_CSRRS, a, '0, '0, got);
  endtask

  // idle cycles carry a write, a trap and an illegal access that must all stay masked.
  task automatic go_idle();
    for (int k = 0; k < 3; k++) begin
      @(posedge clk);
      valid <= 1'b0;
      case (k)
        0: begin
          op   <= OP_CSRRW;
          addr <= rand_legal_addr();
        end
        1: begin
          op   <= OP_ECALL;
          addr <= rand_legal_addr();
        end
        default: begin
          op   <= rand_csr_op();
          addr <= rand_illegal_addr();
        end
      endcase
      wdata <= rand_data();
      pc    <= rand_data();
      @(negedge clk);
      check_value("o_illegal", 64'(illegal), 64'h0);
      check_value("o_redirect", 64'(redirect), 64'h0);
      check_value("o_rdata", rdata, 64'h0);
      check_value("o_redirect_pc", redirect_pc, 64'h0);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
    end
    $display("test %-12s %s, %0d errors", name, (errors == err_mark) ? "ok" : "failed",
             errors - err_mark);
    err_mark = errors;
  endtask

  task automatic test_reset();
    csr_data_t got;
    for (int k = 0; k < 5; k++) begin
      read_csr(addr_table[k], got);
      check_value("reset value", got, (k == 0) ? MSTATUS_RESET : 64'h0);
    end
    go_idle();
    finish_test("reset");
  endtask

  task automatic test_rw();
    csr_data_t got;
    csr_addr_t a;
    repeat (N_RW) begin
      a = rand_legal_addr();
      run_op(OP_CSRRW, a, rand_data(), '0, got);
      read_csr(a, got);
      if (a == CSR_ADDR_MSTATUS) begin
        check_value("mstatus.mpp", 64'(got[12:11]), 64'h3);
      end
      if (a == CSR_ADDR_MTVEC || a == CSR_ADDR_MEPC) begin
        check_value("low address bits", 64'(got[1:0]), 64'h0);
      end
    end
    go_idle();
    finish_test("csrrw");
  endtask

  task automatic test_mixed();
    csr_data_t got;
    csr_addr_t a;
    repeat (N_MIXED) begin
      a = rand_legal_addr();
      run_op(rand_csr_op(), a, rand_data(), '0, got);
      read_csr(a, got);
    end
    go_idle();
    finish_test("csrrs_csrrc");
  endtask

  task automatic test_ecall();
    csr_data_t got;
    csr_data_t p;
    run_op(OP_CSRRW, CSR_ADDR_MTVEC, rand_data(), '0, got);
    run_op(OP_CSRRS, CSR_ADDR_MSTATUS, 64'h1 << MSTATUS_MIE_BIT, '0, got);
    p = rand_data();
    run_op(OP_ECALL, rand_legal_addr(), rand_data(), p, got);
    read_csr(CSR_ADDR_MEPC, got);
    check_value("mepc", got, {p[63:2], 2'b00});
    read_csr(CSR_ADDR_MCAUSE, got);
    check_value("mcause", got, 64'd11);
    read_csr(CSR_ADDR_MSTATUS, got);
    check_value("mstatus.mpie", 64'(got[7]), 64'h1);
    check_value("mstatus.mie", 64'(got[3]), 64'h0);
    go_idle();
    finish_test("ecall");
  endtask

  task automatic test_mret();
    csr_data_t got;
    logic      prev_mpie;
    // the second pass clears MPIE first so that MIE returns as 0.
    for (int k = 0; k < 2; k++) begin
      if (k == 1) begin
        run_op(OP_CSRRC, CSR_ADDR_MSTATUS, 64'h1 << MSTATUS_MPIE_BIT, '0, got);
      end
      prev_mpie = model[0][MSTATUS_MPIE_BIT];
      run_op(OP_MRET, rand_legal_addr(), '0, rand_data(), got);
      read_csr(CSR_ADDR_MSTATUS, got);
      check_value("mstatus.mie", 64'(got[3]), 64'(prev_mpie));
      check_value("mstatus.mpie", 64'(got[7]), 64'h1);
    end
    go_idle();
    finish_test("mret");
  endtask

  task automatic test_illegal();
    csr_data_t got;
    repeat (N_ILLEGAL) begin
      run_op(rand_csr_op(), rand_illegal_addr(), rand_data(), '0, got);
    end
    for (int k = 0; k < 5; k++) begin
      read_csr(addr_table[k], got);
    end
    go_idle();
    finish_test("illegal");
  endtask

  initial begin
    void'($urandom(32'h265e));
    valid = 1'b0;
    op    = OP_CSRRW;
    addr  = '0;
    wdata = '0;
    pc    = '0;
    addr_table[0] = CSR_ADDR_MSTATUS;
    addr_table[1] = CSR_ADDR_MTVEC;
    addr_table[2] = CSR_ADDR_MEPC;
    addr_table[3] = CSR_ADDR_MCAUSE;
    addr_table[4] = CSR_ADDR_MSCRATCH;
    model[0] = MSTATUS_RESET;
    for (int k = 1; k < 5; k++) begin
      model[k] = '0;
    end
    wait (arst_n === 1'b1);
    test_reset();
    test_rw();
    test_mixed();
    test_ecall();
    test_mret();
    test_illegal();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/csr_assertions.sv
// protocol assertions for the CSR top level, bound into csr_top.
`timescale 1ns/1ns
`default_nettype none

module csr_assertions (
  input wire logic               i_clk,
  input wire logic               i_arst_n,
  input wire logic               i_valid,
  input wire logic               i_illegal,
  input wire logic               i_redirect,
  input wire csr_pkg::csr_data_t i_redirect_pc
);

  // a trap is never an illegal CSR access at the same time.
  a_redirect_not_illegal: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_redirect |-> !i_illegal
  ) else $error("redirect raised together with illegal");

  // trap targets come from aligned registers.
  a_redirect_aligned: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_redirect |-> (i_redirect_pc[1:0] == 2'b00)
  ) else $error("redirect target is not 4-byte aligned");

  a_idle_quiet: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    !i_valid |-> (!i_redirect && !i_illegal)
  ) else $error("redirect or illegal high without a valid instruction");

endmodule

bind csr_top csr_assertions u_assertions (
  .i_clk         (i_clk),
  .i_arst_n      (i_arst_n),
  .i_valid       (i_valid),
  .i_illegal     (o_illegal),
  .i_redirect    (o_redirect),
  .i_redirect_pc (o_redirect_pc)
);

`default_nettype wire

// File: test/tb_clkgen.sv
// testbench clock and reset generator with a 100 ns clock and a three-cycle reset.
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_arst_n
);
  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 3;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: hw/csr_top.sv
// csr top joins the control decode with the alu and the register file.
`timescale 1ns/1ns
`default_nettype none

module csr_top (
  input  wire logic               i_clk,
  input  wire logic               i_arst_n,
  input  wire logic               i_valid,
  input  wire csr_pkg::csr_op_t   i_op,
  input  wire csr_pkg::csr_addr_t i_addr,
  input  wire csr_pkg::csr_data_t i_wdata,
  input  wire csr_pkg::csr_data_t i_pc,
  output csr_pkg::csr_data_t      o_rdata,
  output logic                    o_illegal,
  output logic                    o_redirect,
  output csr_pkg::csr_data_t      o_redirect_pc
);
  import csr_pkg::*;

  csr_idx_t  idx;
  logic      wen;
  logic      rd_en;
  logic      ecall;
  logic      mret;
  csr_data_t cur;
  csr_data_t new_val;

  csr_ctrl u_ctrl (
    .i_valid    (i_valid),
    .i_op       (i_op),
    .i_addr     (i_addr),
    .o_idx      (idx),
    .o_wen      (wen),
    .o_rd_en    (rd_en),
    .o_ecall    (ecall),
    .o_mret     (mret),
    .o_redirect (o_redirect),
    .o_illegal  (o_illegal)
  );

  csr_alu u_alu (
    .i_op      (i_op),
    .i_idx     (idx),
    .i_old     (cur),
    .i_operand (i_wdata),
    .o_new     (new_val)
  );

  csr_file u_file (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_idx         (idx),
    .i_wen         (wen),
    .i_rd_en       (rd_en),
    .i_new         (new_val),
    .i_ecall       (ecall),
    .i_mret        (mret),
    .i_pc          (i_pc),
    .o_cur         (cur),
    .o_rdata       (o_rdata),
    .o_redirect_pc (o_redirect_pc)
  );

endmodule

`default_nettype wire

// File: hw/csr_file.sv
// csr register file holds the five machine CSRs, the read mux and the trap side effects.
`timescale 1ns/1ns
`default_nettype none

module csr_file (
  input  wire logic               i_clk,
  input  wire logic               i_arst_n,
  input  wire csr_pkg::csr_idx_t  i_idx,
  input  wire logic               i_wen,
  input  wire logic               i_rd_en,
  input  wire csr_pkg::csr_data_t i_new,
  input  wire logic               i_ecall,
  input  wire logic               i_mret,
  input  wire csr_pkg::csr_data_t i_pc,
  output csr_pkg::csr_data_t      o_cur,
  output csr_pkg::csr_data_t      o_rdata,
  output csr_pkg::csr_data_t      o_redirect_pc
);
  import csr_pkg::*;

  csr_data_t mstatus;
  csr_data_t mtvec;
  csr_data_t mepc;
  csr_data_t mcause;
  csr_data_t mscratch;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mstatus  <= MSTATUS_RESET;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else if (i_wen) begin
      case (i_idx)
        IDX_MSTATUS:  mstatus  <= i_new;
        IDX_MTVEC:    mtvec    <= i_new;
        IDX_MEPC:     mepc     <= i_new;
        IDX_MCAUSE:   mcause   <= i_new;
        IDX_MSCRATCH: mscratch <= i_new;
        default: ;
      endcase
    end else if (i_ecall) begin
      // trap entry saves the aligned pc and stacks the interrupt enable.
      mepc                      <= {i_pc[63:2], 2'b00};
      mcause                    <= MCAUSE_ECALL_M;
      mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
      mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
    end else if (i_mret) begin
      mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
      mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
    end
  end

  always_comb begin
    case (i_idx)
      IDX_MSTATUS:  o_cur = mstatus;
      IDX_MTVEC:    o_cur = mtvec;
      IDX_MEPC:     o_cur = mepc;
      IDX_MCAUSE:   o_cur = mcause;
      IDX_MSCRATCH: o_cur = mscratch;
      default:      o_cur = '0;
    endcase
  end

  assign o_rdata = i_rd_en ? o_cur : '0;

  // direct mode only, so the trap target is mtvec as stored.
  always_comb begin
    if (i_ecall) begin
      o_redirect_pc = mtvec;
    end else if (i_mret) begin
      o_redirect_pc = mepc;
    end else begin
      o_redirect_pc = '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/csr_alu.sv
// csr alu forms the read-modify-write result and legalizes it with the target write mask.
`timescale 1ns/1ns
`default_nettype none

module csr_alu (
  input  wire csr_pkg::csr_op_t   i_op,
  input  wire csr_pkg::csr_idx_t  i_idx,
  input  wire csr_pkg::csr_data_t i_old,
  input  wire csr_pkg::csr_data_t i_operand,
  output csr_pkg::csr_data_t      o_new
);
  import csr_pkg::*;

  csr_data_t cand;
  csr_data_t wmask;

  function automatic csr_data_t mask_of(input csr_idx_t idx);
    csr_data_t m;
    case (idx)
      IDX_MSTATUS:  m = WMASK_MSTATUS;
      IDX_MTVEC:    m = WMASK_MTVEC;
      IDX_MEPC:     m = WMASK_MEPC;
      IDX_MCAUSE:   m = WMASK_MCAUSE;
      IDX_MSCRATCH: m = WMASK_MSCRATCH;
      default:      m = '0;
    endcase
    return m;
  endfunction

  always_comb begin
    case (i_op)
      OP_CSRRW: cand = i_operand;
      OP_CSRRS: cand = i_old | i_operand;
      OP_CSRRC: cand = i_old & ~i_operand;
      default:  cand = i_old;
    endcase
  end

  assign wmask = mask_of(i_idx);

  // read-only bits keep their current value.
  assign o_new = (cand & wmask) | (i_old & ~wmask);

endmodule

`default_nettype wire

// File: hw/csr_ctrl.sv
// csr control decodes the operation and address into register index, strobes and the illegal flag.
`timescale 1ns/1ns
`default_nettype none

module csr_ctrl (
  input  wire logic             i_valid,
  input  wire csr_pkg::csr_op_t   i_op,
  input  wire csr_pkg::csr_addr_t i_addr,
  output csr_pkg::csr_idx_t       o_idx,
  output logic                  o_wen,
  output logic                  o_rd_en,
  output logic                  o_ecall,
  output logic                  o_mret,
  output logic                  o_redirect,
  output logic                  o_illegal
);
  import csr_pkg::*;

  logic addr_hit;
  logic is_csr_op;

  // address lookup, a miss falls back to slot 0 but never writes it.
  always_comb begin
    addr_hit = 1'b1;
    case (i_addr)
      CSR_ADDR_MSTATUS:  o_idx = IDX_MSTATUS;
      CSR_ADDR_MTVEC:    o_idx = IDX_MTVEC;
      CSR_ADDR_MEPC:     o_idx = IDX_MEPC;
      CSR_ADDR_MCAUSE:   o_idx = IDX_MCAUSE;
      CSR_ADDR_MSCRATCH: o_idx = IDX_MSCRATCH;
      default: begin
        o_idx    = IDX_MSTATUS;
        addr_hit = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (i_op)
      OP_CSRRW, OP_CSRRS, OP_CSRRC: is_csr_op = 1'b1;
      default:                      is_csr_op = 1'b0;
    endcase
  end

  assign o_wen     = i_valid & is_csr_op & addr_hit;
  assign o_rd_en   = i_valid & is_csr_op & addr_hit;
  assign o_illegal = i_valid & is_csr_op & ~addr_hit;

  // traps ignore the address field.
  assign o_ecall    = i_valid & (i_op == OP_ECALL);
  assign o_mret     = i_valid & (i_op == OP_MRET);
  assign o_redirect = o_ecall | o_mret;

endmodule

`default_nettype wire

// File: hw/csr_pkg.sv
// machine-mode CSR package with widths, operation codes, addresses, reset values and write masks.
`default_nettype none

package csr_pkg;

  typedef logic [63:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  csr_idx_t;

  typedef enum logic [2:0] {
    OP_CSRRW = 3'd0,
    OP_CSRRS = 3'd1,
    OP_CSRRC = 3'd2,
    OP_ECALL = 3'd3,
    OP_MRET  = 3'd4
  } csr_op_t;

  // architectural CSR addresses from the privileged spec.
  localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;

  // internal register slots.
  localparam csr_idx_t IDX_MSTATUS  = 3'd0;
  localparam csr_idx_t IDX_MTVEC    = 3'd1;
  localparam csr_idx_t IDX_MEPC     = 3'd2;
  localparam csr_idx_t IDX_MCAUSE   = 3'd3;
  localparam csr_idx_t IDX_MSCRATCH = 3'd4;

  // MPP is fixed at machine mode and the SXL/UXL fields read as 64-bit.
  localparam csr_data_t MSTATUS_RESET = 64'h0000_000a_0000_1800;

  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // only MIE and MPIE are writable in an M-only core without interrupts.
  localparam csr_data_t WMASK_MSTATUS  = 64'h0000_0000_0000_0088;
  // trap vector and exception pc are kept 4-byte aligned.
  localparam csr_data_t WMASK_MTVEC    = 64'hffff_ffff_ffff_fffc;
  localparam csr_data_t WMASK_MEPC     = 64'hffff_ffff_ffff_fffc;
  localparam csr_data_t WMASK_MCAUSE   = 64'hffff_ffff_ffff_ffff;
  localparam csr_data_t WMASK_MSCRATCH = 64'hffff_ffff_ffff_ffff;

  // environment call from M-mode.
  localparam csr_data_t MCAUSE_ECALL_M = 64'd11;

endpackage

`default_nettype wire
